// File: design/control_unit.sv
// core control unit
`timescale 1ns/1ps
`default_nettype none

module control_unit
    import cu_status_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  logic           clk_i,
    input  logic           rstn_i,
    input  id_status_t     id_status_i,
    input  iq_status_t     iq_status_i,
    input  rr_status_t     rr_status_i,
    input  exe_status_t    exe_status_i,
    input  wb_status_t     wb_status_i,
    input  commit_status_t commit_status_i,
    input  csr_status_t    csr_status_i,
    input  logic           branch_ok_wb_i,
    input  logic           miss_icache_i,
    input  logic           ready_icache_i,
    input  logic           if2_valid_i,
    input  logic           debug_wr_valid_i,
    input  logic           gl_empty_i,
    input  dbg_req_t       dbg_req_i,
    output stall_vec_t     stall_o,
    output flush_vec_t     flush_o,
    output next_pc_sel_t   next_pc_o,
    output fetch_src_t     fetch_src_o,
    output rf_ctrl_t       rf_ctrl_o,
    output gl_ctrl_t       gl_ctrl_o,
    output logic           invalidate_icache_o,
    output logic           invalidate_buffer_o,
    output dbg_resp_t      dbg_resp_o,
    output logic           halt_csr_ack_o
);

    dbg_flags_t dbg_flags;
    logic       redirect_q;
    logic       fence_pending;
    logic       step_pending;
    logic       step_hold;
    logic       fence_clear;
    logic       step_clear;

    assign halt_csr_ack_o = dbg_flags.halt_csr_ack;

    debug_ctrl u_debug_ctrl (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .dbg_req_i    (dbg_req_i),
        .csr_status_i (csr_status_i),
        .gl_empty_i   (gl_empty_i),
        .redirect_q_i (redirect_q),
        .dbg_resp_o   (dbg_resp_o),
        .dbg_flags_o  (dbg_flags)
    );

    serial_tracker u_serial_tracker (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .id_status_i     (id_status_i),
        .commit_status_i (commit_status_i),
        .csr_status_i    (csr_status_i),
        .if2_valid_i     (if2_valid_i),
        .on_halt_i       (dbg_flags.on_halt),
        .step_active_i   (dbg_flags.step_active),
        .fence_clear_i   (fence_clear),
        .step_clear_i    (step_clear),
        .fence_pending_o (fence_pending),
        .step_pending_o  (step_pending),
        .step_hold_o     (step_hold)
    );

    pipeline_steer u_pipeline_steer (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .id_status_i         (id_status_i),
        .iq_status_i         (iq_status_i),
        .rr_status_i         (rr_status_i),
        .exe_status_i        (exe_status_i),
        .wb_status_i         (wb_status_i),
        .commit_status_i     (commit_status_i),
        .csr_status_i        (csr_status_i),
        .branch_ok_wb_i      (branch_ok_wb_i),
        .miss_icache_i       (miss_icache_i),
        .ready_icache_i      (ready_icache_i),
        .debug_wr_valid_i    (debug_wr_valid_i),
        .dbg_flags_i         (dbg_flags),
        .fence_pending_i     (fence_pending),
        .step_pending_i      (step_pending),
        .step_hold_i         (step_hold),
        .stall_o             (stall_o),
        .flush_o             (flush_o),
        .next_pc_o           (next_pc_o),
        .fetch_src_o         (fetch_src_o),
        .rf_ctrl_o           (rf_ctrl_o),
        .gl_ctrl_o           (gl_ctrl_o),
        .invalidate_icache_o (invalidate_icache_o),
        .invalidate_buffer_o (invalidate_buffer_o),
        .fence_clear_o       (fence_clear),
        .step_clear_o        (step_clear),
        .redirect_q_o        (redirect_q)
    );

endmodule

`default_nettype wire

// File: design/cu_ctrl_pkg.sv
// control outputs and debug port
`default_nettype none
`include "cu_defines.svh"

package cu_ctrl_pkg;

    typedef enum logic [`CU_SEL_W-1:0] {
        NEXT_PC_JUMP,
        NEXT_PC_KEEP,
        NEXT_PC_BP_OR_PC4
    } next_pc_sel_t;

    // where the fetch address comes from on a jump
    typedef enum logic [`CU_SEL_W-1:0] {
        FETCH_SRC_CSR,
        FETCH_SRC_CSR_RW,
        FETCH_SRC_EXE,
        FETCH_SRC_DECODE
    } fetch_src_t;

    typedef enum logic [`CU_DBG_STATE_W-1:0] {
        DBG_RESET,
        DBG_RUNNING,
        DBG_HALTING,
        DBG_HALTED,
        DBG_PROGBUF
    } dbg_state_t;

    typedef struct packed {
        logic if1;
        logic if2;
        logic id;
        logic iq;
        logic ir;
        logic rr;
        logic exe;
        logic commit;
    } stall_vec_t;

    // fetch covers both fetch stages
    typedef struct packed {
        logic fetch;
        logic id;
        logic ir;
        logic rr;
        logic exe;
        logic kill_exe;
        logic commit;
    } flush_vec_t;

    typedef struct packed {
        logic halt_on_reset;
        logic halt_req;
        logic resume_req;
        logic progbuf_req;
    } dbg_req_t;

    typedef struct packed {
        logic halt_ack;
        logic resume_ack;
        logic progbuf_ack;
        logic halted;
        logic running;
    } dbg_resp_t;

    // debug controller view shared with the other blocks
    typedef struct packed {
        logic on_halt;
        logic halt_ack;
        logic halt_csr_ack;
        logic step_active;
    } dbg_flags_t;

    typedef struct packed {
        logic [`CU_NUM_WB-1:0] write_enable;
        logic                  write_enable_dbg;
    } rf_ctrl_t;

    typedef struct packed {
        logic                    flush_gl;
        logic [`CU_GL_IDX_W-1:0] flush_gl_index;
        logic                    flush_gl_commit;
        logic                    enable_commit;
    } gl_ctrl_t;

endpackage

`default_nettype wire

// File: design/cu_defines.svh
// control unit sizes
`ifndef CU_DEFINES_SVH
`define CU_DEFINES_SVH

// scalar write-back ports into the register file
`define CU_NUM_WB 2

// graduation list index width
`define CU_GL_IDX_W 6

// width of the fetch steering selects
`define CU_SEL_W 2

// debug run-control state width
`define CU_DBG_STATE_W 3

`endif

// File: design/cu_status_pkg.sv
// stage status reports
`default_nettype none
`include "cu_defines.svh"

package cu_status_pkg;

    // decode stage
    typedef struct packed {
        logic valid;
        logic valid_jal;
        logic is_branch;
        logic predicted_as_branch;
        logic stall_csr_fence;
    } id_status_t;

    // rename and issue queue
    typedef struct packed {
        logic full_iq;
    } iq_status_t;

    // register read
    typedef struct packed {
        logic gl_full;
    } rr_status_t;

    typedef struct packed {
        logic stall;
    } exe_status_t;

    // one valid and write enable bit per write-back port
    typedef struct packed {
        logic [`CU_NUM_WB-1:0]   valid;
        logic [`CU_NUM_WB-1:0]   write_enable;
        logic [`CU_GL_IDX_W-1:0] gl_index;
    } wb_status_t;

    typedef struct packed {
        logic valid;
        logic xcpt;
        logic ecall_taken;
        logic write_enable;
        logic fence;
        logic fence_i;
        logic stall_csr_fence;
        logic stall_commit;
    } commit_status_t;

    // csr unit, also reports debug events
    typedef struct packed {
        logic csr_stall;
        logic csr_eret;
        logic csr_exception;
        logic debug_ebreak;
        logic debug_step;
    } csr_status_t;

endpackage

`default_nettype wire

// File: design/debug_ctrl.sv
// debug run control
`timescale 1ns/1ps
`default_nettype none

module debug_ctrl
    import cu_status_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  dbg_req_t    dbg_req_i,
    input  csr_status_t csr_status_i,
    input  logic        gl_empty_i,
    input  logic        redirect_q_i,
    output dbg_resp_t   dbg_resp_o,
    output dbg_flags_t  dbg_flags_o
);

    dbg_state_t state_q;
    dbg_state_t state_d;

    always_comb begin
        state_d     = state_q;
        dbg_resp_o  = '0;
        dbg_flags_o = '0;
        case (state_q)
            DBG_RESET: begin
                if (dbg_req_i.halt_on_reset) begin
                    state_d             = DBG_HALTED;
                    dbg_resp_o.halt_ack = 1'b1;
                    dbg_flags_o.on_halt = 1'b1;
                end else begin
                    state_d = DBG_RUNNING;
                end
            end
            DBG_RUNNING: begin
                // ebreak skips the halting phase
                if (csr_status_i.debug_ebreak) begin
                    state_d             = DBG_HALTED;
                    dbg_resp_o.halt_ack = 1'b1;
                end else if (dbg_req_i.halt_req) begin
                    state_d = DBG_HALTING;
                end
                dbg_resp_o.running    = 1'b1;
                dbg_resp_o.resume_ack = dbg_req_i.resume_req;
            end
            DBG_HALTING: begin
                // wait for the graduation list to drain
                if (gl_empty_i || csr_status_i.debug_ebreak) begin
                    state_d                  = DBG_HALTED;
                    dbg_resp_o.halt_ack      = 1'b1;
                    dbg_flags_o.halt_csr_ack = gl_empty_i;
                end
                dbg_flags_o.on_halt = 1'b1;
                dbg_resp_o.running  = 1'b1;
            end
            DBG_HALTED: begin
                if (dbg_req_i.resume_req) begin
                    state_d               = DBG_RUNNING;
                    dbg_resp_o.resume_ack = 1'b1;
                end else if (dbg_req_i.progbuf_req) begin
                    state_d                = DBG_PROGBUF;
                    dbg_resp_o.progbuf_ack = 1'b1;
                end
                dbg_flags_o.on_halt = 1'b1;
                dbg_resp_o.halted   = 1'b1;
            end
            DBG_PROGBUF: begin
                // program buffer ends with ebreak, a trap also brings us back
                if (dbg_req_i.resume_req) begin
                    state_d               = DBG_RUNNING;
                    dbg_resp_o.resume_ack = 1'b1;
                end else if (csr_status_i.debug_ebreak || redirect_q_i) begin
                    state_d             = DBG_HALTED;
                    dbg_resp_o.halt_ack = 1'b1;
                end
                dbg_resp_o.halted = 1'b1;
            end
            default: begin
                state_d = DBG_RESET;
            end
        endcase
        dbg_flags_o.halt_ack    = dbg_resp_o.halt_ack;
        dbg_flags_o.step_active = csr_status_i.debug_step && (state_q == DBG_RUNNING);
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= DBG_RESET;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// File: design/pipeline_steer.sv
// pipeline stall, flush and steering
`timescale 1ns/1ps
`default_nettype none
`include "cu_defines.svh"

module pipeline_steer
    import cu_status_pkg::*;
    import cu_ctrl_pkg::*;
(
    input  logic           clk_i,
    input  logic           rstn_i,
    input  id_status_t     id_status_i,
    input  iq_status_t     iq_status_i,
    input  rr_status_t     rr_status_i,
    input  exe_status_t    exe_status_i,
    input  wb_status_t     wb_status_i,
    input  commit_status_t commit_status_i,
    input  csr_status_t    csr_status_i,
    input  logic           branch_ok_wb_i,
    input  logic           miss_icache_i,
    input  logic           ready_icache_i,
    input  logic           debug_wr_valid_i,
    input  dbg_flags_t     dbg_flags_i,
    input  logic           fence_pending_i,
    input  logic           step_pending_i,
    input  logic           step_hold_i,
    output stall_vec_t     stall_o,
    output flush_vec_t     flush_o,
    output next_pc_sel_t   next_pc_o,
    output fetch_src_t     fetch_src_o,
    output rf_ctrl_t       rf_ctrl_o,
    output gl_ctrl_t       gl_ctrl_o,
    output logic           invalidate_icache_o,
    output logic           invalidate_buffer_o,
    output logic           fence_clear_o,
    output logic           step_clear_o,
    output logic           redirect_q_o
);

    logic mispredict;
    logic bad_pred;
    logic id_serial;
    logic commit_serial;
    logic commit_fence;
    logic xcpt_event;
    logic xcpt_d;
    logic xcpt_q;
    logic csr_d;
    logic csr_q;
    logic serial_busy;
    logic dbg_we;

    assign mispredict    = wb_status_i.valid[0] && !branch_ok_wb_i;
    assign bad_pred      = id_status_i.valid && !id_status_i.is_branch
                           && id_status_i.predicted_as_branch;
    assign id_serial     = id_status_i.valid && id_status_i.stall_csr_fence;
    assign commit_serial = commit_status_i.valid && commit_status_i.stall_csr_fence;
    assign commit_fence  = commit_status_i.valid && commit_status_i.fence;
    assign serial_busy   = id_serial || fence_pending_i || step_hold_i || step_pending_i;
    assign dbg_we        = debug_wr_valid_i && dbg_flags_i.on_halt;

    // traps, eret and debug entry redirect fetch to the csr target
    assign xcpt_event = (commit_status_i.valid
                         && (commit_status_i.xcpt || commit_status_i.ecall_taken))
                        || csr_status_i.csr_eret || csr_status_i.csr_exception
                        || csr_status_i.debug_ebreak || dbg_flags_i.halt_ack;

    // one cycle pulses that never repeat back to back
    assign xcpt_d = !xcpt_q && xcpt_event;
    assign csr_d  = !csr_q && commit_serial && !xcpt_event;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            xcpt_q <= 1'b0;
            csr_q  <= 1'b0;
        end else begin
            xcpt_q <= xcpt_d;
            csr_q  <= csr_d;
        end
    end

    assign redirect_q_o = xcpt_q;

    always_comb begin
        stall_o = '0;
        if (csr_status_i.csr_stall || iq_status_i.full_iq) begin
            stall_o.if1 = 1'b1;
            stall_o.if2 = 1'b1;
            stall_o.id  = 1'b1;
        end else if (miss_icache_i) begin
            stall_o.if1 = 1'b1;
            stall_o.if2 = 1'b1;
        end else if (commit_serial || !ready_icache_i || dbg_flags_i.on_halt
                     || step_hold_i || step_pending_i) begin
            // hold only the first fetch stage
            stall_o.if1 = 1'b1;
        end
        if (csr_status_i.csr_stall) begin
            stall_o.iq  = 1'b1;
            stall_o.ir  = 1'b1;
            stall_o.rr  = 1'b1;
            stall_o.exe = 1'b1;
        end else if (exe_status_i.stall || rr_status_i.gl_full) begin
            stall_o.iq = 1'b1;
            stall_o.ir = 1'b1;
            stall_o.rr = 1'b1;
        end
        stall_o.commit = commit_status_i.stall_commit || csr_status_i.csr_stall;
    end

    always_comb begin
        flush_o       = '0;
        fence_clear_o = 1'b0;
        step_clear_o  = 1'b0;
        if (xcpt_q || csr_q || mispredict) begin
            flush_o.fetch = 1'b1;
            flush_o.id    = 1'b1;
        end else if ((serial_busy || commit_serial || id_status_i.valid_jal || commit_fence
                      || bad_pred) && !csr_status_i.csr_stall) begin
            flush_o.fetch = 1'b1;
        end
        if (xcpt_q) begin
            flush_o.ir     = 1'b1;
            flush_o.rr     = 1'b1;
            flush_o.exe    = 1'b1;
            flush_o.commit = 1'b1;
            fence_clear_o  = 1'b1;
            step_clear_o   = 1'b1;
        end else if (mispredict) begin
            // the branch itself leaves execute normally
            flush_o.ir       = 1'b1;
            flush_o.rr       = 1'b1;
            flush_o.kill_exe = 1'b1;
            fence_clear_o    = 1'b1;
        end else if (!exe_status_i.stall && rr_status_i.gl_full) begin
            flush_o.rr = 1'b1;
        end
    end

    always_comb begin
        if (mispredict || bad_pred || id_status_i.valid_jal || xcpt_q || csr_q) begin
            next_pc_o = NEXT_PC_JUMP;
        end else if (stall_o.if1 || serial_busy || commit_fence || dbg_flags_i.on_halt) begin
            next_pc_o = NEXT_PC_KEEP;
        end else begin
            next_pc_o = NEXT_PC_BP_OR_PC4;
        end
        if (xcpt_q) begin
            fetch_src_o = FETCH_SRC_CSR;
        end else if (csr_q) begin
            fetch_src_o = FETCH_SRC_CSR_RW;
        end else if (mispredict) begin
            fetch_src_o = FETCH_SRC_EXE;
        end else begin
            fetch_src_o = FETCH_SRC_DECODE;
        end
    end

    // port 0 is shared with commit and debug writes
    always_comb begin
        for (int i = 0; i < `CU_NUM_WB; i++) begin
            rf_ctrl_o.write_enable[i] = wb_status_i.valid[i] && wb_status_i.write_enable[i];
        end
        rf_ctrl_o.write_enable[0] = rf_ctrl_o.write_enable[0] || dbg_we
                                    || (commit_status_i.valid && !commit_status_i.xcpt
                                        && !csr_status_i.csr_exception
                                        && commit_status_i.write_enable);
        rf_ctrl_o.write_enable_dbg = dbg_we;
    end

    assign gl_ctrl_o.flush_gl        = mispredict;
    assign gl_ctrl_o.flush_gl_index  = mispredict ? wb_status_i.gl_index : '0;
    assign gl_ctrl_o.flush_gl_commit = xcpt_q;
    assign gl_ctrl_o.enable_commit   = !stall_o.commit && !xcpt_d;

    // fence.i may follow self modifying code
    assign invalidate_icache_o = commit_status_i.valid && commit_status_i.fence_i;
    assign invalidate_buffer_o = commit_status_i.valid
                                 && (commit_status_i.fence_i || xcpt_q || dbg_flags_i.halt_ack
                                     || (commit_status_i.stall_csr_fence
                                         && !commit_status_i.fence));

endmodule

`default_nettype wire

// File: design/serial_tracker.sv
// serializing instruction tracker
`timescale 1ns/1ps
`default_nettype none

module serial_tracker
    import cu_status_pkg::*;
(
    input  logic           clk_i,
    input  logic           rstn_i,
    input  id_status_t     id_status_i,
    input  commit_status_t commit_status_i,
    input  csr_status_t    csr_status_i,
    input  logic           if2_valid_i,
    input  logic           on_halt_i,
    input  logic           step_active_i,
    input  logic           fence_clear_i,
    input  logic           step_clear_i,
    output logic           fence_pending_o,
    output logic           step_pending_o,
    output logic           step_hold_o
);

    logic step_in_if2;
    logic step_in_id;

    assign step_in_if2 = if2_valid_i && step_active_i;
    assign step_in_id  = id_status_i.valid && step_active_i;
    assign step_hold_o = step_in_if2 || step_in_id;

    // csr or fence between decode and commit
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fence_pending_o <= 1'b0;
        end else if (fence_clear_i || csr_status_i.csr_exception) begin
            fence_pending_o <= 1'b0;
        end else if (id_status_i.valid && id_status_i.stall_csr_fence) begin
            fence_pending_o <= 1'b1;
        end else if (commit_status_i.valid && commit_status_i.stall_csr_fence) begin
            fence_pending_o <= 1'b0;
        end
    end

    // stepped instruction left decode, done once the core halts
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            step_pending_o <= 1'b0;
        end else if (step_clear_i || on_halt_i) begin
            step_pending_o <= 1'b0;
        end else if (step_in_id) begin
            step_pending_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+design
design/cu_status_pkg.sv
design/cu_ctrl_pkg.sv
design/debug_ctrl.sv
design/serial_tracker.sv
design/pipeline_steer.sv
design/control_unit.sv
tests/control_unit_asserts.sv
tests/tb_control_unit.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/1ps --top-module tb_control_unit \
    -f list.f -o tb_sim &&
./obj_dir/tb_sim | awk '{ print } /^test passed$/ { ok = 1 } END { exit !ok }' &&
echo "simulation ok" ||
{ echo "simulation not ok"; exit 1; }

// File: tests/control_unit_asserts.sv
// control unit assertions
`timescale 1ns/1ps
`default_nettype none

module control_unit_asserts
    import cu_status_pkg::*;
    import cu_ctrl_pkg::*;
(
    input logic        clk_i,
    input logic        rstn_i,
    input logic        redirect_i,
    input csr_status_t csr_status_i,
    input stall_vec_t  stall_i,
    input dbg_resp_t   dbg_resp_i
);

    int unsigned fail_cnt = 0;

    // exception redirect lasts exactly one cycle
    redirect_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_i |=> !redirect_i)
        else begin
            $error("exception redirect asserted in two consecutive cycles");
            fail_cnt++;
        end

    halt_then_halted: assert property (@(posedge clk_i) disable iff (!rstn_i)
        dbg_resp_i.halt_ack |=> dbg_resp_i.halted)
        else begin
            $error("halt acknowledge was not followed by the halted state");
            fail_cnt++;
        end

    // a csr stall freezes the whole pipeline
    csr_stall_all: assert property (@(posedge clk_i) disable iff (!rstn_i)
        csr_status_i.csr_stall |-> (stall_i == '1))
        else begin
            $error("csr stall did not set every stall bit");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: tests/tb_control_unit.sv
// control unit testbench
`timescale 1ns/1ps
`default_nettype none
`include "cu_defines.svh"

module tb_control_unit
    import cu_status_pkg::*;
    import cu_ctrl_pkg::*;
;

    localparam int RST_CYCLES = 16;

    // one row is one cycle of stimulus and the outputs expected in it
    typedef struct packed {
        int             test_id;
        id_status_t     id;
        iq_status_t     iq;
        rr_status_t     rr;
        exe_status_t    exe;
        wb_status_t     wb;
        commit_status_t cm;
        csr_status_t    csr;
        logic           br_ok;
        logic           miss;
        logic           ready;
        logic           dbg_wr;
        logic           gl_empty;
        dbg_req_t       req;
        stall_vec_t     stall;
        flush_vec_t     flush;
        next_pc_sel_t   npc;
        fetch_src_t     src;
        rf_ctrl_t       rf;
        gl_ctrl_t       gl;
        logic           inv_ic;
        logic           inv_buf;
        dbg_resp_t      resp;
        logic           hcack;
    } row_t;

    logic           clk_i;
    logic           rstn_i;
    id_status_t     id_status_i;
    iq_status_t     iq_status_i;
    rr_status_t     rr_status_i;
    exe_status_t    exe_status_i;
    wb_status_t     wb_status_i;
    commit_status_t commit_status_i;
    csr_status_t    csr_status_i;
    logic           branch_ok_wb_i;
    logic           miss_icache_i;
    logic           ready_icache_i;
    logic           if2_valid_i;
    logic           debug_wr_valid_i;
    logic           gl_empty_i;
    dbg_req_t       dbg_req_i;
    stall_vec_t     stall_o;
    flush_vec_t     flush_o;
    next_pc_sel_t   next_pc_o;
    fetch_src_t     fetch_src_o;
    rf_ctrl_t       rf_ctrl_o;
    gl_ctrl_t       gl_ctrl_o;
    logic           invalidate_icache_o;
    logic           invalidate_buffer_o;
    dbg_resp_t      dbg_resp_o;
    logic           halt_csr_ack_o;

    row_t  rows[$];
    string names[6] = '{"idle", "mispredict", "commit_xcpt", "stall_prio", "fence", "debug"};
    int    mismatches = 0;
    int    tests_run = 0;
    int    tests_bad = 0;
    int    cycles = 0;
    int    cycle_limit = RST_CYCLES + 100;
    int    base_mm = 0;
    int    rows_in_test = 0;
    int    total = 0;

    control_unit u_control_unit (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .id_status_i         (id_status_i),
        .iq_status_i         (iq_status_i),
        .rr_status_i         (rr_status_i),
        .exe_status_i        (exe_status_i),
        .wb_status_i         (wb_status_i),
        .commit_status_i     (commit_status_i),
        .csr_status_i        (csr_status_i),
        .branch_ok_wb_i      (branch_ok_wb_i),
        .miss_icache_i       (miss_icache_i),
        .ready_icache_i      (ready_icache_i),
        .if2_valid_i         (if2_valid_i),
        .debug_wr_valid_i    (debug_wr_valid_i),
        .gl_empty_i          (gl_empty_i),
        .dbg_req_i           (dbg_req_i),
        .stall_o             (stall_o),
        .flush_o             (flush_o),
        .next_pc_o           (next_pc_o),
        .fetch_src_o         (fetch_src_o),
        .rf_ctrl_o           (rf_ctrl_o),
        .gl_ctrl_o           (gl_ctrl_o),
        .invalidate_icache_o (invalidate_icache_o),
        .invalidate_buffer_o (invalidate_buffer_o),
        .dbg_resp_o          (dbg_resp_o),
        .halt_csr_ack_o      (halt_csr_ack_o)
    );

    bind control_unit control_unit_asserts u_asserts (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .redirect_i   (redirect_q),
        .csr_status_i (csr_status_i),
        .stall_i      (stall_o),
        .dbg_resp_i   (dbg_resp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    // quiet pipeline in the running state
    function automatic row_t idle_row(input int test_id);
        row_t r;
        r = '0;
        r.test_id = test_id;
        r.br_ok = 1'b1;
        r.ready = 1'b1;
        r.npc = NEXT_PC_BP_OR_PC4;
        r.src = FETCH_SRC_DECODE;
        r.gl.enable_commit = 1'b1;
        r.resp.running = 1'b1;
        return r;
    endfunction

    task automatic build_table();
        row_t r;
        // first row still sees the reset state
        r = idle_row(0);
        r.resp = 5'h00;
        rows.push_back(r);
        rows.push_back(idle_row(0));
        r = idle_row(1);
        r.wb.valid = 2'b01;
        r.br_ok = 1'b0;
        r.wb.gl_index = 6'h2a;
        r.flush = 7'h7a;
        r.npc = NEXT_PC_JUMP;
        r.src = FETCH_SRC_EXE;
        r.gl.flush_gl = 1'b1;
        r.gl.flush_gl_index = 6'h2a;
        rows.push_back(r);
        r = idle_row(1);
        r.wb.valid = 2'b11;
        r.wb.write_enable = 2'b11;
        r.rf = 3'b110;
        rows.push_back(r);
        // exception at commit and its redirect one cycle later
        r = idle_row(2);
        r.cm.valid = 1'b1;
        r.cm.xcpt = 1'b1;
        r.gl.enable_commit = 1'b0;
        rows.push_back(r);
        // the exception is still reported but raises no second redirect
        r = idle_row(2);
        r.cm.valid = 1'b1;
        r.cm.xcpt = 1'b1;
        r.flush = 7'h7d;
        r.npc = NEXT_PC_JUMP;
        r.src = FETCH_SRC_CSR;
        r.gl.flush_gl_commit = 1'b1;
        r.inv_buf = 1'b1;
        rows.push_back(r);
        rows.push_back(idle_row(2));
        r = idle_row(3);
        r.csr.csr_stall = 1'b1;
        r.stall = 8'hff;
        r.npc = NEXT_PC_KEEP;
        r.gl.enable_commit = 1'b0;
        rows.push_back(r);
        r = idle_row(3);
        r.iq.full_iq = 1'b1;
        r.stall = 8'he0;
        r.npc = NEXT_PC_KEEP;
        rows.push_back(r);
        r = idle_row(3);
        r.miss = 1'b1;
        r.stall = 8'hc0;
        r.npc = NEXT_PC_KEEP;
        rows.push_back(r);
        r = idle_row(3);
        r.ready = 1'b0;
        r.stall = 8'h80;
        r.npc = NEXT_PC_KEEP;
        rows.push_back(r);
        r = idle_row(3);
        r.rr.gl_full = 1'b1;
        r.stall = 8'h1c;
        r.flush = 7'h08;
        rows.push_back(r);
        r.iq.full_iq = 1'b1;
        r.stall = 8'hfc;
        r.npc = NEXT_PC_KEEP;
        rows.push_back(r);
        r = idle_row(3);
        r.miss = 1'b1;
        r.exe.stall = 1'b1;
        r.stall = 8'hdc;
        r.npc = NEXT_PC_KEEP;
        rows.push_back(r);
        r = idle_row(3);
        r.csr.csr_stall = 1'b1;
        r.iq.full_iq = 1'b1;
        r.miss = 1'b1;
        r.rr.gl_full = 1'b1;
        r.stall = 8'hff;
        r.flush = 7'h08;
        r.npc = NEXT_PC_KEEP;
        r.gl.enable_commit = 1'b0;
        rows.push_back(r);
        // csr fence from decode to commit
        r = idle_row(4);
        r.id.valid = 1'b1;
        r.id.stall_csr_fence = 1'b1;
        r.flush = 7'h40;
        r.npc = NEXT_PC_KEEP;
        rows.push_back(r);
        r = idle_row(4);
        r.flush = 7'h40;
        r.npc = NEXT_PC_KEEP;
        rows.push_back(r);
        rows.push_back(r);
        r.cm.valid = 1'b1;
        r.cm.stall_csr_fence = 1'b1;
        r.stall = 8'h80;
        r.inv_buf = 1'b1;
        rows.push_back(r);
        r = idle_row(4);
        r.flush = 7'h60;
        r.npc = NEXT_PC_JUMP;
        r.src = FETCH_SRC_CSR_RW;
        rows.push_back(r);
        rows.push_back(idle_row(4));
        r = idle_row(4);
        r.cm.valid = 1'b1;
        r.cm.fence_i = 1'b1;
        r.inv_ic = 1'b1;
        r.inv_buf = 1'b1;
        rows.push_back(r);
        r = idle_row(4);
        r.cm.valid = 1'b1;
        r.cm.fence = 1'b1;
        r.flush = 7'h40;
        r.npc = NEXT_PC_KEEP;
        rows.push_back(r);
        // halt, debug write and resume
        r = idle_row(5);
        r.req.halt_req = 1'b1;
        rows.push_back(r);
        r = idle_row(5);
        r.stall = 8'h80;
        r.npc = NEXT_PC_KEEP;
        rows.push_back(r);
        r.gl_empty = 1'b1;
        r.resp = 5'h11;
        r.hcack = 1'b1;
        r.gl.enable_commit = 1'b0;
        rows.push_back(r);
        r = idle_row(5);
        r.resp = 5'h02;
        r.stall = 8'h80;
        r.flush = 7'h7d;
        r.npc = NEXT_PC_JUMP;
        r.src = FETCH_SRC_CSR;
        r.gl.flush_gl_commit = 1'b1;
        rows.push_back(r);
        r = idle_row(5);
        r.resp = 5'h02;
        r.stall = 8'h80;
        r.npc = NEXT_PC_KEEP;
        rows.push_back(r);
        r.dbg_wr = 1'b1;
        r.rf = 3'b011;
        rows.push_back(r);
        r.dbg_wr = 1'b0;
        r.rf = 3'b000;
        r.req.resume_req = 1'b1;
        r.resp = 5'h0a;
        rows.push_back(r);
        rows.push_back(idle_row(5));
    endtask

    // fields that cannot affect the outputs get random values
    task automatic drive_row(input row_t r);
        id_status_i = r.id;
        iq_status_i = r.iq;
        rr_status_i = r.rr;
        exe_status_i = r.exe;
        wb_status_i = r.wb;
        if (!r.gl.flush_gl) begin
            wb_status_i.gl_index = `CU_GL_IDX_W'($urandom);
        end
        wb_status_i.write_enable = r.wb.write_enable | (`CU_NUM_WB'($urandom) & ~r.wb.valid);
        commit_status_i = r.cm;
        csr_status_i = r.csr;
        branch_ok_wb_i = r.br_ok;
        miss_icache_i = r.miss;
        ready_icache_i = r.ready;
        if2_valid_i = 1'($urandom);
        debug_wr_valid_i = r.dbg_wr;
        gl_empty_i = r.gl_empty;
        dbg_req_i = r.req;
    endtask

    task automatic check_val(input int row, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Fail row %0d %s: got 0x%0h, expected 0x%0h", row, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_row(input int idx, input row_t r);
        check_val(idx, "stall_o", 32'(stall_o), 32'(r.stall));
        check_val(idx, "flush_o", 32'(flush_o), 32'(r.flush));
        check_val(idx, "next_pc_o", 32'(next_pc_o), 32'(r.npc));
        check_val(idx, "fetch_src_o", 32'(fetch_src_o), 32'(r.src));
        check_val(idx, "rf_ctrl_o", 32'(rf_ctrl_o), 32'(r.rf));
        check_val(idx, "gl_ctrl_o", 32'(gl_ctrl_o), 32'(r.gl));
        check_val(idx, "invalidate_icache_o", 32'(invalidate_icache_o), 32'(r.inv_ic));
        check_val(idx, "invalidate_buffer_o", 32'(invalidate_buffer_o), 32'(r.inv_buf));
        check_val(idx, "dbg_resp_o", 32'(dbg_resp_o), 32'(r.resp));
        check_val(idx, "halt_csr_ack_o", 32'(halt_csr_ack_o), 32'(r.hcack));
    endtask

    initial begin
        void'($urandom(32'hc431_ce79));
        build_table();
        cycle_limit = RST_CYCLES + rows.size() + 20;
        rstn_i = 1'b0;
        drive_row(idle_row(0));
        repeat (RST_CYCLES) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        // drive 1 ns after the edge, check 2 ns later
        foreach (rows[i]) begin
            drive_row(rows[i]);
            #2;
            check_row(i, rows[i]);
            rows_in_test++;
            if (i == rows.size() - 1 || rows[i + 1].test_id != rows[i].test_id) begin
                $display("%-12s %0d rows, %0d mismatches", names[rows[i].test_id],
                         rows_in_test, mismatches - base_mm);
                tests_run++;
                if (mismatches != base_mm) begin
                    tests_bad++;
                end
                base_mm = mismatches;
                rows_in_test = 0;
            end
            @(posedge clk_i);
            #1;
        end
        total = mismatches + int'(u_control_unit.u_asserts.fail_cnt);
        $display("%0d tests, %0d with mismatches, %0d mismatches, %0d assertion failures",
                 tests_run, tests_bad, mismatches, u_control_unit.u_asserts.fail_cnt);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
